/* flist.f */
design/eth_tx_pkg.sv
design/slicing_crc.sv
design/tx_frame_buffer.sv
design/tx_mac.sv
design/eth_tx_top.sv
dv/tb_clock_gen.sv
dv/tb_eth_tx.sv

/* Bender.yml */
package:
  name: eth_tx

sources:
  - design/eth_tx_pkg.sv
  - design/slicing_crc.sv
  - design/tx_frame_buffer.sv
  - design/tx_mac.sv
  - design/eth_tx_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_eth_tx.sv

/* dv/tb_eth_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_eth_tx;

    // About 1000 cycles of frame traffic, with a fourfold margin
    localparam int max_cycles = 4000;

    logic clk;
    logic reset;
    logic [eth_tx_pkg::data_width-1:0]  s_tdata;
    logic [eth_tx_pkg::data_nbytes-1:0] s_tkeep;
    logic                               s_tvalid;
    logic                               s_tready;
    logic                               s_tlast;
    logic [eth_tx_pkg::data_width-1:0]  xgmii_tx_data;
    logic [eth_tx_pkg::data_nbytes-1:0] xgmii_tx_ctl;
    logic                               phy_tx_ready;

    // Payload of the next frame, expected and collected frames
    logic [7:0] payload [$];
    logic [7:0] exp_bytes [$];
    int exp_lens [$];
    logic [7:0] rx_bytes [$];
    int rx_lens [$];
    int rx_gaps [$];
    logic [7:0] last_frame [$];

    bit in_frame = 1'b0;
    int frame_len = 0;
    int idle_run = 0;
    int stall_words = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycle_count = 0;
    int seed;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    eth_tx_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .s_tdata       (s_tdata),
        .s_tkeep       (s_tkeep),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tlast       (s_tlast),
        .xgmii_tx_data (xgmii_tx_data),
        .xgmii_tx_ctl  (xgmii_tx_ctl),
        .phy_tx_ready  (phy_tx_ready)
    );

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure: %s", msg);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errors_before);
    endtask

    // Reflected CRC-32, one message bit at a time
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            c = (c >> 1) ^ ((c[0] ^ b[k]) ? eth_tx_pkg::crc_poly : 32'h0);
        end
        return c;
    endfunction

    task automatic make_payload(input int len);
        payload = {};
        for (int i = 0; i < len; i++) begin
            payload.push_back($urandom_range(255));
        end
    endtask

    // Preamble, payload padded to the minimum size, FCS low byte first
    task automatic push_expected();
        logic [31:0] crc;
        logic [7:0] b;
        int n;
        n = (payload.size() < eth_tx_pkg::min_frame_size) ?
            eth_tx_pkg::min_frame_size : payload.size();
        repeat (6) exp_bytes.push_back(eth_tx_pkg::mac_pre);
        exp_bytes.push_back(eth_tx_pkg::mac_sfd);
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < n; i++) begin
            b = (i < payload.size()) ? payload[i] : 8'h00;
            exp_bytes.push_back(b);
            crc = crc_update(crc, b);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            exp_bytes.push_back(crc[8*k +: 8]);
        end
        exp_lens.push_back(7 + n + 4);
    endtask

    task automatic check_idle_word();
        compare_value("xgmii_tx_data", xgmii_tx_data, eth_tx_pkg::idle_word);
        compare_value("xgmii_tx_ctl", xgmii_tx_ctl, 4'hF);
    endtask

    task automatic send_frame(input bit idle_expected);
        int idx;
        int len;
        logic [31:0] word;
        logic [3:0] keep;
        len = payload.size();
        if (len == 0 || len > eth_tx_pkg::buf_depth_words * eth_tx_pkg::data_nbytes) begin
            report_failure($sformatf("frame length %0d does not fit the buffer", len));
            return;
        end
        push_expected();
        idx = 0;
        while (idx < len) begin
            @(negedge clk);
            word = '0;
            keep = '0;
            for (int k = 0; k < 4; k++) begin
                if (idx + k < len) begin
                    word[8*k +: 8] = payload[idx + k];
                    keep[k] = 1'b1;
                end
            end
            s_tdata = word;
            s_tkeep = keep;
            s_tvalid = 1'b1;
            s_tlast = (idx + 4 >= len);
            @(posedge clk);
            if (idle_expected) begin
                check_idle_word();
            end
            if (s_tready) begin
                idx += 4;
            end
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tkeep = '0;
        s_tdata = '0;
    endtask

    task automatic check_frames(input int n, input bit check_gap);
        int got_len;
        int exp_len;
        int gap;
        logic [7:0] got_b;
        logic [7:0] exp_b;
        while (rx_lens.size() < n) @(posedge clk);
        for (int f = 0; f < n; f++) begin
            got_len = rx_lens.pop_front();
            exp_len = exp_lens.pop_front();
            gap = rx_gaps.pop_front();
            if (got_len != exp_len) begin
                report_failure($sformatf("frame truncated or too long, %0d bytes instead of %0d",
                                         got_len, exp_len));
            end
            if (check_gap && gap < eth_tx_pkg::ipg_size) begin
                report_failure($sformatf("only %0d idle bytes before a frame", gap));
            end
            last_frame = {};
            for (int i = 0; i < got_len; i++) begin
                got_b = rx_bytes.pop_front();
                last_frame.push_back(got_b);
                if (i < exp_len) begin
                    compare_value($sformatf("xgmii_tx_data byte %0d", i), got_b, exp_bytes[i]);
                end
            end
            repeat (exp_len) exp_b = exp_bytes.pop_front();
        end
    endtask

    // XGMII monitor, one lane at a time
    task automatic collect_lane(input logic [7:0] b, input logic c);
        if (c && b == eth_tx_pkg::rs_start) begin
            if (in_frame) begin
                report_failure("start character inside a frame, terminate missing");
                rx_lens.push_back(frame_len);
            end
            in_frame = 1'b1;
            frame_len = 0;
            rx_gaps.push_back(idle_run);
        end else if (in_frame) begin
            if (c && b == eth_tx_pkg::rs_term) begin
                in_frame = 1'b0;
                rx_lens.push_back(frame_len);
                idle_run = 0;
            end else if (c) begin
                report_failure($sformatf("control byte %h inside a frame", b));
            end else begin
                rx_bytes.push_back(b);
                frame_len++;
            end
        end else if (c && b == eth_tx_pkg::rs_idle) begin
            idle_run++;
        end else begin
            report_failure($sformatf("unexpected byte %h outside a frame", b));
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (!phy_tx_ready) begin
                // Only stalls that cut into a frame count
                if (in_frame) begin
                    stall_words++;
                end
                compare_value("xgmii_tx_data", xgmii_tx_data, eth_tx_pkg::error_word);
                compare_value("xgmii_tx_ctl", xgmii_tx_ctl, 4'hF);
            end else begin
                for (int i = 0; i < eth_tx_pkg::data_nbytes; i++) begin
                    collect_lane(xgmii_tx_data[8*i +: 8], xgmii_tx_ctl[i]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, a frame never completed", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic reset_idle();
        int errors_before;
        errors_before = errors;
        repeat (8) begin
            @(posedge clk);
            check_idle_word();
            compare_value("s_tready", s_tready, 1'b1);
        end
        make_payload(64);
        send_frame(1'b1);
        check_frames(1, 1'b0);
        report_test("reset_idle", errors_before);
    endtask

    task automatic frame_64();
        int errors_before;
        errors_before = errors;
        make_payload(64);
        send_frame(1'b0);
        check_frames(1, 1'b0);
        report_test("frame_64", errors_before);
    endtask

    task automatic short_frame_padding();
        int errors_before;
        errors_before = errors;
        make_payload(17);
        send_frame(1'b0);
        make_payload(1);
        send_frame(1'b0);
        check_frames(2, 1'b0);
        report_test("short_frame_padding", errors_before);
    endtask

    // 61 to 64 bytes move the terminate through all four lanes
    task automatic terminate_lanes();
        int errors_before;
        errors_before = errors;
        for (int len = 61; len <= 64; len++) begin
            make_payload(len);
            send_frame(1'b0);
            check_frames(1, 1'b0);
        end
        report_test("terminate_lanes", errors_before);
    endtask

    task automatic back_to_back();
        int errors_before;
        errors_before = errors;
        make_payload(70);
        send_frame(1'b0);
        make_payload(100);
        send_frame(1'b0);
        make_payload(64);
        send_frame(1'b0);
        check_frames(3, 1'b1);
        report_test("back_to_back", errors_before);
    endtask

    task automatic phy_stalls();
        int errors_before;
        int stalls_before;
        logic [7:0] clean [$];
        errors_before = errors;
        make_payload(90);
        send_frame(1'b0);
        check_frames(1, 1'b0);
        clean = last_frame;
        stalls_before = stall_words;
        fork
            send_frame(1'b0);
            begin
                while (rx_lens.size() == 0) begin
                    @(negedge clk);
                    phy_tx_ready = ($urandom_range(3) != 0);
                end
                @(negedge clk);
                phy_tx_ready = 1'b1;
            end
        join
        check_frames(1, 1'b0);
        if (stall_words == stalls_before) begin
            report_failure("no PHY stall happened during the frame");
        end
        if (last_frame.size() != clean.size()) begin
            report_failure("stalled frame length differs from the unstalled frame");
        end else begin
            for (int i = 0; i < clean.size(); i++) begin
                compare_value($sformatf("xgmii_tx_data byte %0d", i), last_frame[i], clean[i]);
            end
        end
        report_test("phy_stalls", errors_before);
    endtask

    initial begin
        seed = $urandom(79102);
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        phy_tx_ready = 1'b1;
        wait (reset === 1'b0);
        @(negedge clk);
        reset_idle();
        frame_64();
        short_frame_padding();
        terminate_lanes();
        back_to_back();
        phy_stalls();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset spans three rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* design/eth_tx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_tx_top (
    input  wire                                clk,
    input  wire                                reset,
    // User frame stream
    input  wire [eth_tx_pkg::data_width-1:0]   s_tdata,
    input  wire [eth_tx_pkg::data_nbytes-1:0]  s_tkeep,
    input  wire                                s_tvalid,
    output logic                               s_tready,
    input  wire                                s_tlast,
    // XGMII transmit
    output logic [eth_tx_pkg::data_width-1:0]  xgmii_tx_data,
    output logic [eth_tx_pkg::data_nbytes-1:0] xgmii_tx_ctl,
    input  wire                                phy_tx_ready
);

    // Whole frames from the buffer to the MAC
    logic [eth_tx_pkg::data_width-1:0]  m_tdata;
    logic [eth_tx_pkg::data_nbytes-1:0] m_tkeep;
    logic                               m_tvalid;
    logic                               m_tready;
    logic                               m_tlast;

    tx_frame_buffer u_buffer (
        .clk      (clk),
        .reset    (reset),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    tx_mac u_mac (
        .clk           (clk),
        .reset         (reset),
        .m_tdata       (m_tdata),
        .m_tkeep       (m_tkeep),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast),
        .xgmii_tx_data (xgmii_tx_data),
        .xgmii_tx_ctl  (xgmii_tx_ctl),
        .phy_tx_ready  (phy_tx_ready)
    );

endmodule

`default_nettype wire

/* design/tx_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_mac (
    input  wire                                clk,
    input  wire                                reset,
    // Frame stream from the buffer
    input  wire [eth_tx_pkg::data_width-1:0]   m_tdata,
    input  wire [eth_tx_pkg::data_nbytes-1:0]  m_tkeep,
    input  wire                                m_tvalid,
    output logic                               m_tready,
    input  wire                                m_tlast,
    // XGMII
    output logic [eth_tx_pkg::data_width-1:0]  xgmii_tx_data,
    output logic [eth_tx_pkg::data_nbytes-1:0] xgmii_tx_ctl,
    input  wire                                phy_tx_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_data,
        st_padding,
        st_term,
        st_ipg
    } tx_state_t;

    tx_state_t state;
    tx_state_t next_state;

    // Stage 0 feeds the CRC, stage 1 feeds the XGMII output
    logic [eth_tx_pkg::data_width-1:0]  s0_data;
    logic [eth_tx_pkg::data_width-1:0]  s1_data;
    logic [eth_tx_pkg::data_nbytes-1:0] s0_keep;
    logic [eth_tx_pkg::data_nbytes-1:0] s1_keep;
    logic s0_valid;
    logic s1_valid;
    logic s0_last;
    logic s1_last;
    logic s0_pad;

    // Next stage 0 word, either a user beat or a zero pad word
    logic [eth_tx_pkg::data_width-1:0]  d0_data;
    logic [eth_tx_pkg::data_nbytes-1:0] d0_keep;
    logic [eth_tx_pkg::data_width-1:0]  keep_mask;
    logic d0_valid;
    logic d0_last;
    logic in_xfer;
    logic pad_gen;
    logic short_frame;
    logic seen_last;
    logic [eth_tx_pkg::frame_cnt_width-1:0] load_cnt;

    logic [31:0] crc;
    logic [eth_tx_pkg::data_nbytes-1:0] crc_valid;
    logic crc_reset;

    // Tail word plus the two words after it
    logic [2:0][eth_tx_pkg::data_width-1:0]  tail_data;
    logic [2:0][eth_tx_pkg::data_nbytes-1:0] tail_ctl;
    logic [eth_tx_pkg::gap_cnt_width-1:0]    tail_gap;
    logic [1:0][eth_tx_pkg::data_width-1:0]  term_data;
    logic [1:0][eth_tx_pkg::data_nbytes-1:0] term_ctl;
    logic term_idx;
    logic [eth_tx_pkg::gap_cnt_width-1:0]    gap_cnt;

    always_comb begin
        for (int i = 0; i < eth_tx_pkg::data_nbytes; i++) begin
            keep_mask[8*i +: 8] = {8{m_tkeep[i]}};
        end
    end

    assign m_tready = phy_tx_ready && !seen_last &&
                      ((state == st_idle && m_tvalid) || state == st_preamble || state == st_data);
    assign in_xfer = m_tvalid && m_tready;

    // Below the minimum size every word counts as four bytes, unused lanes are zero
    assign short_frame = load_cnt < eth_tx_pkg::min_frame_size;
    assign pad_gen = seen_last && short_frame;
    assign d0_valid = in_xfer || pad_gen;
    assign d0_data = in_xfer ? (m_tdata & keep_mask) : '0;
    assign d0_keep = !d0_valid ? '0 : (short_frame ? '1 : m_tkeep);
    assign d0_last = ((in_xfer && m_tlast) || pad_gen) &&
                     (load_cnt + eth_tx_pkg::frame_cnt_step >= eth_tx_pkg::min_frame_size);

    always_comb begin
        next_state = state;
        xgmii_tx_data = eth_tx_pkg::idle_word;
        xgmii_tx_ctl = '1;
        if (!phy_tx_ready) begin
            xgmii_tx_data = eth_tx_pkg::error_word;
        end else begin
            case (state)
                st_idle: begin
                    if (m_tvalid) begin
                        next_state = st_preamble;
                        xgmii_tx_data = eth_tx_pkg::start_word;
                        xgmii_tx_ctl = eth_tx_pkg::start_ctl;
                    end
                end
                st_preamble: begin
                    next_state = st_data;
                    xgmii_tx_data = eth_tx_pkg::preamble_word;
                    xgmii_tx_ctl = '0;
                end
                st_data, st_padding: begin
                    if (!s1_valid) begin
                        // Broken frame, abort it
                        next_state = st_idle;
                        xgmii_tx_data = eth_tx_pkg::error_word;
                    end else if (s1_last) begin
                        next_state = st_term;
                        xgmii_tx_data = tail_data[0];
                        xgmii_tx_ctl = tail_ctl[0];
                    end else begin
                        next_state = s0_pad ? st_padding : st_data;
                        xgmii_tx_data = s1_data;
                        xgmii_tx_ctl = '0;
                    end
                end
                st_term: begin
                    if (term_idx) begin
                        next_state = st_ipg;
                    end
                    xgmii_tx_data = term_data[term_idx];
                    xgmii_tx_ctl = term_ctl[term_idx];
                end
                st_ipg: begin
                    if (gap_cnt + eth_tx_pkg::gap_cnt_step >= eth_tx_pkg::ipg_size) begin
                        next_state = st_idle;
                    end
                end
                default: begin
                    next_state = st_idle;
                end
            endcase
        end
    end

    // FCS goes out low byte first, so it drops straight into the lanes
    always_comb begin
        tail_data[0] = s1_data;
        tail_ctl[0] = '0;
        tail_data[1] = eth_tx_pkg::idle_word;
        tail_ctl[1] = '1;
        tail_data[2] = eth_tx_pkg::idle_word;
        tail_ctl[2] = '1;
        case (s1_keep)
            4'b1111: begin
                tail_data[1] = crc;
                tail_ctl[1] = '0;
                tail_data[2] = {{3{eth_tx_pkg::rs_idle}}, eth_tx_pkg::rs_term};
                tail_gap = 5'd3;
            end
            4'b0111: begin
                tail_data[0] = {crc[7:0], s1_data[23:0]};
                tail_data[1] = {eth_tx_pkg::rs_term, crc[31:8]};
                tail_ctl[1] = 4'b1000;
                tail_gap = 5'd4;
            end
            4'b0011: begin
                tail_data[0] = {crc[15:0], s1_data[15:0]};
                tail_data[1] = {eth_tx_pkg::rs_idle, eth_tx_pkg::rs_term, crc[31:16]};
                tail_ctl[1] = 4'b1100;
                tail_gap = 5'd5;
            end
            4'b0001: begin
                tail_data[0] = {crc[23:0], s1_data[7:0]};
                tail_data[1] = {{2{eth_tx_pkg::rs_idle}}, eth_tx_pkg::rs_term, crc[31:24]};
                tail_ctl[1] = 4'b1110;
                tail_gap = 5'd6;
            end
            default: begin
                tail_data[0] = eth_tx_pkg::error_word;
                tail_ctl[0] = '1;
                tail_data[1] = eth_tx_pkg::error_word;
                tail_gap = 5'd0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            seen_last <= 1'b0;
            load_cnt <= '0;
            term_idx <= 1'b0;
            gap_cnt <= '0;
            s0_valid <= 1'b0;
            s0_last <= 1'b0;
            s0_pad <= 1'b0;
            s1_valid <= 1'b0;
            s1_last <= 1'b0;
        end else if (phy_tx_ready) begin
            state <= next_state;
            if (next_state == st_idle) begin
                seen_last <= 1'b0;
                load_cnt <= '0;
            end else begin
                seen_last <= seen_last || (in_xfer && m_tlast);
                if (d0_valid && short_frame) begin
                    load_cnt <= load_cnt + eth_tx_pkg::frame_cnt_step;
                end
            end
            term_idx <= (state == st_term) && !term_idx;
            if (state != st_term && next_state == st_term) begin
                gap_cnt <= tail_gap;
            end else if (state == st_ipg) begin
                gap_cnt <= gap_cnt + eth_tx_pkg::gap_cnt_step;
            end
            s0_valid <= d0_valid;
            s0_last <= d0_last;
            s0_pad <= pad_gen;
            s1_valid <= s0_valid;
            s1_last <= s0_last;
        end
    end

    always_ff @(posedge clk) begin
        if (phy_tx_ready) begin
            s0_data <= d0_data;
            s0_keep <= d0_keep;
            s1_data <= s0_data;
            s1_keep <= s0_keep;
            if (state != st_term && next_state == st_term) begin
                term_data <= tail_data[2:1];
                term_ctl <= tail_ctl[2:1];
            end
        end
    end

    // CRC takes each word one cycle before it reaches the output
    assign crc_valid = {eth_tx_pkg::data_nbytes{phy_tx_ready && s0_valid}} & s0_keep;
    assign crc_reset = reset || (state == st_idle);

    slicing_crc u_crc (
        .clk   (clk),
        .reset (crc_reset),
        .data  (s0_data),
        .valid (crc_valid),
        .crc   (crc)
    );

    a_stall_error: assert property (@(posedge clk) disable iff (reset)
        !phy_tx_ready |-> (xgmii_tx_ctl == '1) ##1 (state == $past(state)))
        else $error("MAC did not freeze with error words during a PHY stall");

    a_ready_states: assert property (@(posedge clk) disable iff (reset)
        !(state inside {st_idle, st_preamble, st_data}) |-> !m_tready)
        else $error("m_tready high outside idle, preamble or data");

endmodule

`default_nettype wire

/* design/tx_frame_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_frame_buffer (
    input  wire                                clk,
    input  wire                                reset,
    // User side
    input  wire [eth_tx_pkg::data_width-1:0]   s_tdata,
    input  wire [eth_tx_pkg::data_nbytes-1:0]  s_tkeep,
    input  wire                                s_tvalid,
    output logic                               s_tready,
    input  wire                                s_tlast,
    // MAC side
    output logic [eth_tx_pkg::data_width-1:0]  m_tdata,
    output logic [eth_tx_pkg::data_nbytes-1:0] m_tkeep,
    output logic                               m_tvalid,
    input  wire                                m_tready,
    output logic                               m_tlast
);

    // Entry is {last, keep, data}
    logic [eth_tx_pkg::data_width+eth_tx_pkg::data_nbytes:0] mem [eth_tx_pkg::buf_depth_words];

    // Extra pointer bit separates full from empty
    logic [eth_tx_pkg::buf_addr_width:0] wr_ptr;
    logic [eth_tx_pkg::buf_addr_width:0] rd_ptr;
    logic [eth_tx_pkg::buf_addr_width:0] frame_count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;
    logic out_valid;
    logic out_fire;
    logic frame_in;
    logic frame_out;

    assign full = (wr_ptr[eth_tx_pkg::buf_addr_width] != rd_ptr[eth_tx_pkg::buf_addr_width]) &&
                  (wr_ptr[eth_tx_pkg::buf_addr_width-1:0] == rd_ptr[eth_tx_pkg::buf_addr_width-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign s_tready = !full;
    assign wr_en = s_tvalid && s_tready;

    // Output register always holds the next beat; it is offered only once its frame is complete
    assign m_tvalid = out_valid && (frame_count != '0);
    assign out_fire = m_tvalid && m_tready;
    assign rd_en = !empty && (!out_valid || out_fire);

    assign frame_in = wr_en && s_tlast;
    assign frame_out = out_fire && m_tlast;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[eth_tx_pkg::buf_addr_width-1:0]] <= {s_tlast, s_tkeep, s_tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            {m_tlast, m_tkeep, m_tdata} <= mem[rd_ptr[eth_tx_pkg::buf_addr_width-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            out_valid <= 1'b0;
            frame_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_fire) begin
                out_valid <= 1'b0;
            end
            case ({frame_in, frame_out})
                2'b10: frame_count <= frame_count + 1'b1;
                2'b01: frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        full |=> (wr_ptr == $past(wr_ptr)))
        else $error("frame buffer written while full");

    // MAC needs an unbroken frame once the first beat is offered
    a_valid_held: assert property (@(posedge clk) disable iff (reset)
        (m_tvalid && !(m_tready && m_tlast)) |=> m_tvalid)
        else $error("m_tvalid dropped inside a frame");

endmodule

`default_nettype wire

/* design/slicing_crc.sv */
`timescale 1ns/100ps
`default_nettype none

module slicing_crc (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [eth_tx_pkg::data_width-1:0]   data,
    input  wire [eth_tx_pkg::data_nbytes-1:0]  valid,
    output logic [31:0]                        crc
);

    logic [31:0] crc_state;
    logic [31:0] crc_next;

    // One byte through the reflected polynomial, LSB first
    function automatic logic [31:0] fold_byte(
        input logic [31:0] c,
        input logic [7:0]  b
    );
        logic [31:0] r;
        r = c ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            if (r[0]) begin
                r = (r >> 1) ^ eth_tx_pkg::crc_poly;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    // The flop holds the inverted value, so the running remainder is its complement
    assign crc_state = ~crc;

    // Lanes fold in transmit order, lane 0 first
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < eth_tx_pkg::data_nbytes; i++) begin
            if (valid[i]) begin
                crc_next = fold_byte(crc_next, data[8*i +: 8]);
            end
        end
    end

    // All zeros here is the all-ones preset
    always_ff @(posedge clk) begin
        if (reset) begin
            crc <= '0;
        end else begin
            crc <= ~crc_next;
        end
    end

endmodule

`default_nettype wire

/* design/eth_tx_pkg.sv */
`default_nettype none

package eth_tx_pkg;

    // Datapath width
    localparam int data_width = 32;
    localparam int data_nbytes = data_width / 8;

    // XGMII control characters
    localparam logic [7:0] rs_idle = 8'h07;
    localparam logic [7:0] rs_start = 8'hFB;
    localparam logic [7:0] rs_term = 8'hFD;
    localparam logic [7:0] rs_error = 8'hFE;

    // Preamble and start of frame delimiter
    localparam logic [7:0] mac_pre = 8'h55;
    localparam logic [7:0] mac_sfd = 8'hD5;

    // Frame limits in bytes, FCS not included
    localparam int min_frame_size = 60;
    localparam int ipg_size = 12;

    localparam int buf_depth_words = 512;
    localparam int buf_addr_width = $clog2(buf_depth_words);

    // Byte counters in the MAC
    localparam int frame_cnt_width = $clog2(min_frame_size) + 1;
    localparam int gap_cnt_width = 5;
    localparam logic [frame_cnt_width-1:0] frame_cnt_step = frame_cnt_width'(data_nbytes);
    localparam logic [gap_cnt_width-1:0] gap_cnt_step = gap_cnt_width'(data_nbytes);

    // Reflected CRC-32
    localparam logic [31:0] crc_poly = 32'hEDB88320;

    // Whole XGMII words, lane 0 in the low byte
    localparam logic [data_width-1:0] idle_word = {data_nbytes{rs_idle}};
    localparam logic [data_width-1:0] error_word = {data_nbytes{rs_error}};
    localparam logic [data_width-1:0] start_word = {mac_pre, mac_pre, mac_pre, rs_start};
    localparam logic [data_nbytes-1:0] start_ctl = 4'b0001;
    localparam logic [data_width-1:0] preamble_word = {mac_sfd, mac_pre, mac_pre, mac_pre};

endpackage

`default_nettype wire
